//--- tb.f
verilog/glb_geom_pkg.sv
verilog/glb_ctrl_pkg.sv
verilog/glb_addr_counter.sv
verilog/glb_bank_map.sv
verilog/glb_bank_array.sv
verilog/glb_flow_fsm.sv
verilog/glb_top.sv
sim/glb_clk_gen.sv
sim/glb_props.sv
sim/glb_checker.sv
sim/glb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the GLB testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module glb_tb -f tb.f -o glb_sim

sim_status=0
./obj_dir/glb_sim +verilator+error+limit+1000 > sim.log 2>&1 || sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ] || grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- sim/glb_tb.sv
// Testbench top: test sequence, LFSR stimulus, timeout and closing summary
`default_nettype none
`timescale 1ns/10ps

module glb_tb
    import glb_geom_pkg::*;
    import glb_ctrl_pkg::*;
();

    localparam int NUM_TESTS   = 5;
    localparam int MAX_LEN     = 80;
    localparam int TIMEOUT_CYC = NUM_TESTS * (4 * MAX_LEN + 20);
    localparam int DRIVE_DLY   = 1;

    logic                clk;
    logic                rst_n;
    logic                cfg_vld_i;
    logic [NUM_BANK-1:0] cfg_bank_flag_i;
    logic [PAR_W-1:0]    cfg_par_i;
    glb_count_t          cfg_num_i;
    logic                cfg_rdy_o;
    logic                wr_vld_i;
    logic [DATA_W-1:0]   wr_data_i;
    logic                wr_rdy_o;
    logic                rd_vld_o;
    logic [DATA_W-1:0]   rd_data_o;
    logic                rd_rdy_i;
    logic                buf_full_o;
    logic                buf_empty_o;
    glb_count_t          wr_req_num_o;
    glb_count_t          rd_req_num_o;
    int                  chk_errs;
    int                  chk_beats;
    logic [15:0]         lfsr;
    int                  tb_errs;
    int                  tests_failed;
    int                  test_err0;
    int                  test_beat0;
    int                  cycle_cnt = 0;

    glb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    glb_top uut (
        .clk (clk), .rst_n (rst_n),
        .cfg_vld_i (cfg_vld_i), .cfg_bank_flag_i (cfg_bank_flag_i),
        .cfg_par_i (cfg_par_i), .cfg_num_i (cfg_num_i), .cfg_rdy_o (cfg_rdy_o),
        .wr_vld_i (wr_vld_i), .wr_data_i (wr_data_i), .wr_rdy_o (wr_rdy_o),
        .rd_vld_o (rd_vld_o), .rd_data_o (rd_data_o), .rd_rdy_i (rd_rdy_i),
        .buf_full_o (buf_full_o), .buf_empty_o (buf_empty_o),
        .wr_req_num_o (wr_req_num_o), .rd_req_num_o (rd_req_num_o)
    );

    glb_checker u_checker (
        .clk (clk), .rst_n (rst_n),
        .cfg_vld_i (cfg_vld_i), .cfg_bank_flag_i (cfg_bank_flag_i),
        .cfg_par_i (cfg_par_i), .cfg_num_i (cfg_num_i), .cfg_rdy_i (cfg_rdy_o),
        .wr_vld_i (wr_vld_i), .wr_data_i (wr_data_i), .wr_rdy_i (wr_rdy_o),
        .rd_vld_i (rd_vld_o), .rd_data_i (rd_data_o), .rd_rdy_i (rd_rdy_i),
        .buf_full_i (buf_full_o), .buf_empty_i (buf_empty_o),
        .wr_req_num_i (wr_req_num_o), .rd_req_num_i (rd_req_num_o),
        .err_cnt_o (chk_errs), .beat_cnt_o (chk_beats)
    );

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1 and one step per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int error_total();
        return tb_errs + chk_errs + uut.u_fsm.u_props.fail_cnt;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        tb_errs++;
    endtask

    task automatic start_test();
        test_err0  = error_total();
        test_beat0 = chk_beats;
    endtask

    task automatic close_test(input int num, input string name);
        int errs;
        errs = error_total() - test_err0;
        $display("test %0d %s: %s, %0d beats, %0d errors", num, name,
                 (errs == 0) ? "passed" : "failed", chk_beats - test_beat0, errs);
        if (errs != 0) begin
            tests_failed++;
        end
    endtask

    // ==========================================================
    // One configured transfer
    // ==========================================================
    // Read ready is always high in rd_mode 0, random in 1 and held low until full in 2
    task automatic run_stream(input logic [NUM_BANK-1:0] flag, input logic [PAR_W-1:0] par,
                              input int len, input int rd_mode, input int poke_at);
        logic [15:0] rnd;
        int          wr_sent;
        int          cyc;
        int          hold_left;
        int          beats0;
        bit          full_seen;
        wr_sent   = 0;
        cyc       = 0;
        hold_left = 4;
        full_seen = 1'b0;
        beats0    = chk_beats;
        @(posedge clk);
        #DRIVE_DLY;
        cfg_vld_i       = 1'b1;
        cfg_bank_flag_i = flag;
        cfg_par_i       = par;
        cfg_num_i       = glb_count_t'(len);
        @(posedge clk);
        #DRIVE_DLY;
        cfg_vld_i = 1'b0;
        @(negedge clk);
        if (cfg_rdy_o !== 1'b0) begin
            report_mismatch("cfg_rdy_o still high one cycle after config");
        end
        // Ends once the last beat is read and config opens again
        while (!(cfg_rdy_o === 1'b1 && wr_sent == len)) begin
            @(posedge clk);
            #DRIVE_DLY;
            cfg_vld_i = (cyc == poke_at);
            if (cyc == poke_at) begin
                cfg_bank_flag_i = NUM_BANK'(1);
                cfg_par_i       = PAR_W'(1);
                cfg_num_i       = glb_count_t'(7);
            end
            rnd       = take_bits(1);
            wr_vld_i  = (wr_sent < len) && rnd[0];
            wr_data_i = take_bits(DATA_W);
            rnd       = take_bits(1);
            case (rd_mode)
                0:       rd_rdy_i = 1'b1;
                1:       rd_rdy_i = rnd[0];
                default: rd_rdy_i = full_seen && (hold_left == 0) && rnd[0];
            endcase
            @(negedge clk);
            if (wr_vld_i && wr_rdy_o) begin
                wr_sent++;
            end
            if (rd_mode == 2 && buf_full_o && hold_left > 0) begin
                full_seen = 1'b1;
                hold_left--;
                if (wr_rdy_o !== 1'b0 || rd_vld_o !== 1'b1) begin
                    report_mismatch("wr_rdy_o or rd_vld_o wrong while buffer is full");
                end
            end
            cyc++;
        end
        if (rd_mode == 2 && !full_seen) begin
            $display("buf_full_o never rose while reads were held back");
            tb_errs++;
        end
        if (chk_beats - beats0 != len) begin
            report_mismatch($sformatf("%0d beats read for length %0d", chk_beats - beats0, len));
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        cfg_vld_i       = 1'b0;
        cfg_bank_flag_i = '0;
        cfg_par_i       = '0;
        cfg_num_i       = '0;
        wr_vld_i        = 1'b0;
        wr_data_i       = '0;
        rd_rdy_i        = 1'b0;
        lfsr            = 16'd42331;
        tb_errs         = 0;
        tests_failed    = 0;
        wait (rst_n === 1'b1);
        @(negedge clk);

        start_test();
        if (cfg_rdy_o !== 1'b1 || wr_rdy_o !== 1'b0 || rd_vld_o !== 1'b0) begin
            report_mismatch("ready and valid outputs wrong after reset");
        end
        run_stream(4'b0001, 2'd1, 8, 0, -1);
        close_test(1, "reset and config handshake");

        start_test();
        run_stream(4'b0100, 2'd1, 40, 1, -1);
        close_test(2, "one bank range wrap");

        start_test();
        run_stream(4'b1100, 2'd2, 24, 1, -1);
        run_stream(4'b0011, 2'd1, 24, 1, -1);
        close_test(3, "two banks par 2 and par 1");

        start_test();
        run_stream(4'b1111, 2'd1, MAX_LEN, 2, -1);
        close_test(4, "four banks full under back-pressure");

        start_test();
        run_stream(4'b1111, 2'd2, 60, 1, 10);
        close_test(5, "status counts and config during run");

        $display("Summary: %0d tests, %0d failed, %0d errors, %0d cycles",
                 NUM_TESTS, tests_failed, error_total(), cycle_cnt);
        if (error_total() == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/glb_checker.sv
// Reference model of the buffer stream with per-cycle port comparison
`default_nettype none
`timescale 1ns/10ps

module glb_checker
    import glb_geom_pkg::*;
    import glb_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld_i,
    input  logic [NUM_BANK-1:0] cfg_bank_flag_i,
    input  logic [PAR_W-1:0]    cfg_par_i,
    input  glb_count_t          cfg_num_i,
    input  logic                cfg_rdy_i,
    input  logic                wr_vld_i,
    input  logic [DATA_W-1:0]   wr_data_i,
    input  logic                wr_rdy_i,
    input  logic                rd_vld_i,
    input  logic [DATA_W-1:0]   rd_data_i,
    input  logic                rd_rdy_i,
    input  logic                buf_full_i,
    input  logic                buf_empty_i,
    input  glb_count_t          wr_req_num_i,
    input  glb_count_t          rd_req_num_i,
    output int                  err_cnt_o,
    output int                  beat_cnt_o
);

    logic [DATA_W-1:0]   beat_q [$];
    logic [DATA_W-1:0]   held_data;
    logic [PAR_W-1:0]    par_q;
    int                  len_q;
    int                  range_q;
    int                  wr_cnt;
    int                  rd_iss;
    bit                  run_q;
    bit                  slot_q;
    bit                  held_q;

    // Beats that fit in the flagged banks
    function automatic int span_beats(input logic [NUM_BANK-1:0] flag,
                                      input logic [PAR_W-1:0] par);
        int n;
        n = 0;
        for (int b = 0; b < NUM_BANK; b++) begin
            n += int'(flag[b]);
        end
        return (par == 2) ? (n * BANK_WORDS) / 2 : n * BANK_WORDS;
    endfunction

    // Lanes at or above par come back as zero
    function automatic logic [DATA_W-1:0] mask_lanes(input logic [DATA_W-1:0] data,
                                                     input logic [PAR_W-1:0] par);
        logic [DATA_W-1:0] kept;
        kept = data;
        for (int k = 0; k < MAX_PAR; k++) begin
            if (k >= int'(par)) begin
                kept[k*LANE_W +: LANE_W] = '0;
            end
        end
        return kept;
    endfunction

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s is %b, model expects %b", $time, name, got, exp);
            err_cnt_o++;
        end
    endtask

    task automatic expect_num(input string name, input glb_count_t got, input int exp);
        if ($isunknown(got) || int'(got) != exp) begin
            $display("** Error @ %0t: %s is %0d, model expects %0d", $time, name, got, exp);
            err_cnt_o++;
        end
    endtask

    // ==========================================================
    // Model step, sampled mid-cycle where all ports are settled
    // ==========================================================
    always @(negedge clk) begin
        int                outst;
        int                wr_room;
        bit                exp_wr_rdy;
        bit                wr_acc;
        bit                rd_acc;
        bit                issue;
        bit                done;
        logic [DATA_W-1:0] exp_data;
        if (!rst_n) begin
            beat_q.delete();
            run_q      = 1'b0;
            slot_q     = 1'b0;
            held_q     = 1'b0;
            wr_cnt     = 0;
            rd_iss     = 0;
            err_cnt_o  = 0;
            beat_cnt_o = 0;
        end else begin
            outst      = wr_cnt - rd_iss;
            wr_room    = range_q - outst;
            exp_wr_rdy = run_q && (outst < range_q) && (wr_cnt < len_q);

            expect_bit("cfg_rdy_o", cfg_rdy_i, !run_q);
            expect_bit("wr_rdy_o", wr_rdy_i, exp_wr_rdy);
            expect_bit("rd_vld_o", rd_vld_i, slot_q);
            expect_bit("buf_empty_o", buf_empty_i, run_q && (outst == 0));
            expect_bit("buf_full_o", buf_full_i, run_q && (outst == range_q));
            expect_num("rd_req_num_o", rd_req_num_i, run_q ? outst : 0);
            expect_num("wr_req_num_o", wr_req_num_i,
                       !run_q ? 0 : ((len_q - wr_cnt < wr_room) ? len_q - wr_cnt : wr_room));
            if (held_q && rd_data_i !== held_data) begin
                $display("** Error @ %0t: rd_data_o changed under back-pressure, %h to %h",
                         $time, held_data, rd_data_i);
                err_cnt_o++;
            end

            // Handshakes that complete on the coming edge
            wr_acc = wr_vld_i && exp_wr_rdy;
            rd_acc = slot_q && rd_rdy_i;
            issue  = run_q && (rd_iss < wr_cnt) && (!slot_q || rd_rdy_i);
            done   = run_q && (rd_iss == len_q) && !slot_q;

            if (rd_acc) begin
                if (beat_q.size() == 0) begin
                    $display("Read beat at %0t with no write beat left in the model", $time);
                    err_cnt_o++;
                end else begin
                    exp_data = beat_q.pop_front();
                    if (rd_data_i !== exp_data) begin
                        $display("** Error @ %0t: read beat %0d is %h, expected %h",
                                 $time, beat_cnt_o, rd_data_i, exp_data);
                        err_cnt_o++;
                    end
                end
                beat_cnt_o++;
            end
            if (wr_acc) begin
                beat_q.push_back(mask_lanes(wr_data_i, par_q));
                wr_cnt++;
            end

            held_q    = slot_q && !rd_rdy_i;
            held_data = rd_data_i;
            if (issue) begin
                rd_iss++;
            end
            slot_q = issue || (slot_q && !rd_rdy_i);

            if (done) begin
                run_q = 1'b0;
            end else if (!run_q && cfg_vld_i) begin
                run_q   = 1'b1;
                par_q   = cfg_par_i;
                len_q   = int'(cfg_num_i);
                range_q = span_beats(cfg_bank_flag_i, cfg_par_i);
                wr_cnt  = 0;
                rd_iss  = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/glb_props.sv
// Concurrent assertions on the flow FSM, bound to every FSM instance
`default_nettype none
`timescale 1ns/10ps

module glb_props
    import glb_ctrl_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input glb_state_e state_i,
    input logic       cfg_vld_i,
    input logic       cfg_rdy_i,
    input glb_count_t rd_count_i,
    input glb_count_t num_i,
    input logic       wr_rdy_i,
    input logic       rd_vld_i,
    input logic       rd_rdy_i
);

    // Number of failed assertions
    int fail_cnt = 0;

    // Held beat stays valid until the consumer takes it
    rd_vld_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld_i && !rd_rdy_i) |=> rd_vld_i)
        else begin
            $error("rd_vld_o dropped while rd_rdy_i was low");
            fail_cnt++;
        end

    // IDLE without a config stays IDLE with writes closed
    idle_no_write_a: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == GLB_IDLE && !cfg_vld_i) |=> !wr_rdy_i)
        else begin
            $error("wr_rdy_o high after an IDLE cycle without config");
            fail_cnt++;
        end

    // Config stays closed until the whole transfer is read
    run_no_cfg_a: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == GLB_RUN && rd_count_i != num_i) |=> !cfg_rdy_i)
        else begin
            $error("cfg_rdy_o high before the transfer was read");
            fail_cnt++;
        end

endmodule

bind glb_flow_fsm glb_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .state_i    (state_q),
    .cfg_vld_i  (cfg_vld_i),
    .cfg_rdy_i  (cfg_rdy_o),
    .rd_count_i (rd_count_i),
    .num_i      (cfg_num_q),
    .wr_rdy_i   (wr_rdy_o),
    .rd_vld_i   (rd_vld_i),
    .rd_rdy_i   (rd_rdy_i)
);

`default_nettype wire

//--- sim/glb_clk_gen.sv
// Testbench clock and power-on reset generator
`default_nettype none
`timescale 1ns/10ps

module glb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release just after the third rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/glb_top.sv
// Buffer top level joining the FSM, address counters, bank mappers and bank array
`default_nettype none
`timescale 1ns/10ps

module glb_top
    import glb_geom_pkg::*;
    import glb_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld_i,
    input  logic [NUM_BANK-1:0] cfg_bank_flag_i,
    input  logic [PAR_W-1:0]    cfg_par_i,
    input  glb_count_t          cfg_num_i,
    output logic                cfg_rdy_o,
    input  logic                wr_vld_i,
    input  logic [DATA_W-1:0]   wr_data_i,
    output logic                wr_rdy_o,
    output logic                rd_vld_o,
    output logic [DATA_W-1:0]   rd_data_o,
    input  logic                rd_rdy_i,
    output logic                buf_full_o,
    output logic                buf_empty_o,
    output glb_count_t          wr_req_num_o,
    output glb_count_t          rd_req_num_o
);

    logic [NUM_BANK-1:0]   bank_flag;
    logic [PAR_W-1:0]      par;
    logic                  clear;
    logic                  wr_inc;
    logic                  rd_issue;
    glb_addr_u             wr_addr;
    glb_addr_u             rd_addr;
    glb_count_t            range;
    logic [BANK_IDX_W-1:0] wr_first_bank;
    logic [BANK_IDX_W-1:0] rd_first_bank;
    logic [ROW_W-1:0]      wr_row;
    logic [ROW_W-1:0]      rd_row;

    // ==========================================================
    // Control
    // ==========================================================
    glb_flow_fsm u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld_i       (cfg_vld_i),
        .cfg_bank_flag_i (cfg_bank_flag_i),
        .cfg_par_i       (cfg_par_i),
        .cfg_num_i       (cfg_num_i),
        .cfg_rdy_o       (cfg_rdy_o),
        .bank_flag_o     (bank_flag),
        .par_o           (par),
        .clear_o         (clear),
        .wr_count_i      (wr_addr.flat),
        .rd_count_i      (rd_addr.flat),
        .range_i         (range),
        .wr_vld_i        (wr_vld_i),
        .wr_rdy_o        (wr_rdy_o),
        .wr_inc_o        (wr_inc),
        .rd_issue_o      (rd_issue),
        .rd_vld_i        (rd_vld_o),
        .rd_rdy_i        (rd_rdy_i),
        .buf_full_o      (buf_full_o),
        .buf_empty_o     (buf_empty_o),
        .wr_req_num_o    (wr_req_num_o),
        .rd_req_num_o    (rd_req_num_o)
    );

    // ==========================================================
    // Address generation and mapping
    // ==========================================================
    glb_addr_counter u_wr_cnt (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear_i (clear),
        .inc_i   (wr_inc),
        .count_o (wr_addr)
    );

    glb_addr_counter u_rd_cnt (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear_i (clear),
        .inc_i   (rd_issue),
        .count_o (rd_addr)
    );

    glb_bank_map u_wr_map (
        .addr_i       (wr_addr),
        .bank_flag_i  (bank_flag),
        .par_i        (par),
        .range_o      (range),
        .first_bank_o (wr_first_bank),
        .row_o        (wr_row)
    );

    // Same config on both sides, the write range serves both
    glb_bank_map u_rd_map (
        .addr_i       (rd_addr),
        .bank_flag_i  (bank_flag),
        .par_i        (par),
        .range_o      (),
        .first_bank_o (rd_first_bank),
        .row_o        (rd_row)
    );

    // ==========================================================
    // Storage
    // ==========================================================
    glb_bank_array u_banks (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_en_i         (wr_inc),
        .wr_first_bank_i (wr_first_bank),
        .wr_row_i        (wr_row),
        .par_i           (par),
        .wr_data_i       (wr_data_i),
        .rd_issue_i      (rd_issue),
        .rd_first_bank_i (rd_first_bank),
        .rd_row_i        (rd_row),
        .rd_rdy_i        (rd_rdy_i),
        .rd_data_o       (rd_data_o),
        .rd_vld_o        (rd_vld_o)
    );

endmodule

`default_nettype wire

//--- verilog/glb_flow_fsm.sv
// Flow FSM with config registers, write ready, read issue and buffer status
`default_nettype none
`timescale 1ns/10ps

module glb_flow_fsm
    import glb_geom_pkg::*;
    import glb_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld_i,
    input  logic [NUM_BANK-1:0] cfg_bank_flag_i,
    input  logic [PAR_W-1:0]    cfg_par_i,
    input  glb_count_t          cfg_num_i,
    output logic                cfg_rdy_o,
    output logic [NUM_BANK-1:0] bank_flag_o,
    output logic [PAR_W-1:0]    par_o,
    output logic                clear_o,
    input  glb_count_t          wr_count_i,
    input  glb_count_t          rd_count_i,
    input  glb_count_t          range_i,
    input  logic                wr_vld_i,
    output logic                wr_rdy_o,
    output logic                wr_inc_o,
    output logic                rd_issue_o,
    input  logic                rd_vld_i,
    input  logic                rd_rdy_i,
    output logic                buf_full_o,
    output logic                buf_empty_o,
    output glb_count_t          wr_req_num_o,
    output glb_count_t          rd_req_num_o
);

    glb_state_e state_q;
    glb_state_e state_d;
    glb_count_t cfg_num_q;
    glb_count_t outstanding;
    glb_count_t wr_left;
    glb_count_t room;
    logic       run;
    logic       cfg_accept;
    logic       done;

    // ==========================================================
    // State and config registers
    // ==========================================================
    assign run        = (state_q == GLB_RUN);
    assign cfg_rdy_o  = (state_q == GLB_IDLE);
    assign cfg_accept = cfg_vld_i & cfg_rdy_o;
    assign clear_o    = cfg_accept;

    // Whole transfer read and the output slot drained
    assign done = (rd_count_i == cfg_num_q) && !rd_vld_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            GLB_IDLE: begin
                if (cfg_accept) begin
                    state_d = GLB_RUN;
                end
            end
            GLB_RUN: begin
                if (done) begin
                    state_d = GLB_IDLE;
                end
            end
            default: state_d = GLB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= GLB_IDLE;
            bank_flag_o <= '0;
            par_o       <= '0;
            cfg_num_q   <= '0;
        end else begin
            state_q <= state_d;
            if (cfg_accept) begin
                bank_flag_o <= cfg_bank_flag_i;
                par_o       <= cfg_par_i;
                cfg_num_q   <= cfg_num_i;
            end
        end
    end

    // ==========================================================
    // Write accept and read issue
    // ==========================================================
    assign outstanding = wr_count_i - rd_count_i;
    assign wr_left     = cfg_num_q - wr_count_i;
    assign room        = range_i - outstanding;

    assign wr_rdy_o   = run && (outstanding < range_i) && (wr_count_i < cfg_num_q);
    assign wr_inc_o   = wr_vld_i & wr_rdy_o;
    // Stall issue while a held beat waits for the consumer
    assign rd_issue_o = run && (rd_count_i < wr_count_i) && (!rd_vld_i || rd_rdy_i);

    // Status, all zero in IDLE
    assign buf_full_o   = run && (outstanding == range_i);
    assign buf_empty_o  = run && (wr_count_i == rd_count_i);
    assign rd_req_num_o = run ? outstanding : '0;
    assign wr_req_num_o = !run ? '0 : ((wr_left < room) ? wr_left : room);

endmodule

`default_nettype wire

//--- verilog/glb_bank_array.sv
// Bank SRAM array with lane routing and a held read output register
`default_nettype none
`timescale 1ns/10ps

module glb_bank_array
    import glb_geom_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en_i,
    input  logic [BANK_IDX_W-1:0] wr_first_bank_i,
    input  logic [ROW_W-1:0]      wr_row_i,
    input  logic [PAR_W-1:0]      par_i,
    input  logic [DATA_W-1:0]     wr_data_i,
    input  logic                  rd_issue_i,
    input  logic [BANK_IDX_W-1:0] rd_first_bank_i,
    input  logic [ROW_W-1:0]      rd_row_i,
    input  logic                  rd_rdy_i,
    output logic [DATA_W-1:0]     rd_data_o,
    output logic                  rd_vld_o
);

    logic [LANE_W-1:0]   mem [NUM_BANK][BANK_WORDS];
    logic [NUM_BANK-1:0] wr_hit;
    logic [LANE_W-1:0]   wr_word [NUM_BANK];
    logic [DATA_W-1:0]   rd_gather;

    // ==========================================================
    // Write lane routing
    // ==========================================================
    // Lane k lands in bank first + k when k is below par
    always_comb begin
        logic [BANK_IDX_W-1:0] lane_bank;
        for (int b = 0; b < NUM_BANK; b++) begin
            wr_hit[b]  = 1'b0;
            wr_word[b] = '0;
        end
        for (int k = 0; k < MAX_PAR; k++) begin
            lane_bank = wr_first_bank_i + BANK_IDX_W'(k);
            if (PAR_W'(k) < par_i) begin
                wr_hit[lane_bank]  = 1'b1;
                wr_word[lane_bank] = wr_data_i[k*LANE_W +: LANE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANK; b++) begin
            if (wr_en_i && wr_hit[b]) begin
                mem[b][wr_row_i] <= wr_word[b];
            end
        end
    end

    // ==========================================================
    // Read gather and output register
    // ==========================================================
    // Unused lanes stay zero
    always_comb begin
        logic [BANK_IDX_W-1:0] lane_bank;
        rd_gather = '0;
        for (int k = 0; k < MAX_PAR; k++) begin
            lane_bank = rd_first_bank_i + BANK_IDX_W'(k);
            if (PAR_W'(k) < par_i) begin
                rd_gather[k*LANE_W +: LANE_W] = mem[lane_bank][rd_row_i];
            end
        end
    end

    // Issue only comes when the slot is free, so data just loads
    always_ff @(posedge clk) begin
        if (rd_issue_i) begin
            rd_data_o <= rd_gather;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_o <= 1'b0;
        end else if (rd_issue_i) begin
            rd_vld_o <= 1'b1;
        end else if (rd_rdy_i) begin
            rd_vld_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/glb_bank_map.sv
// Address to bank mapper: flagged bank count, lowest bank, valid range, first bank and row
`default_nettype none
`timescale 1ns/10ps

module glb_bank_map
    import glb_geom_pkg::*;
    import glb_ctrl_pkg::*;
(
    input  glb_addr_u              addr_i,
    input  logic [NUM_BANK-1:0]    bank_flag_i,
    input  logic [PAR_W-1:0]       par_i,
    output glb_count_t             range_o,
    output logic [BANK_IDX_W-1:0]  first_bank_o,
    output logic [ROW_W-1:0]       row_o
);

    logic [NBANK_W-1:0]      num_bank;
    logic [BANK_IDX_W-1:0]   low_bank;
    glb_count_t              words;
    glb_addr_u               addr_red;
    logic [ADDR_W-ROW_W-1:0] step_off;

    // ==========================================================
    // Bank allocation from the flag mask
    // ==========================================================
    // Walk down so the last hit is the lowest flagged bank
    always_comb begin
        num_bank = '0;
        low_bank = '0;
        for (int b = NUM_BANK - 1; b >= 0; b--) begin
            if (bank_flag_i[b]) begin
                num_bank = num_bank + 1'b1;
                low_bank = BANK_IDX_W'(b);
            end
        end
    end

    // Range in beats, each beat spans par banks
    assign words   = glb_count_t'(num_bank) * glb_count_t'(BANK_WORDS);
    assign range_o = (par_i > PAR_W'(1)) ? (words >> 1) : words;

    // ==========================================================
    // Address decode
    // ==========================================================
    // Ranges are powers of two, a mask does the modulo
    assign addr_red.flat = addr_i.flat & (range_o - 1'b1);

    // Each bank step moves par banks up from the lowest one
    assign step_off     = addr_red.split.step * (ADDR_W-ROW_W)'(par_i);
    assign first_bank_o = low_bank + step_off[BANK_IDX_W-1:0];
    assign row_o        = addr_red.split.row;

endmodule

`default_nettype wire

//--- verilog/glb_addr_counter.sv
// Clearable beat address counter
`default_nettype none
`timescale 1ns/10ps

module glb_addr_counter
    import glb_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear_i,
    input  logic      inc_i,
    output glb_addr_u count_o
);

    // Clear wins over increment so a new config starts at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_o <= '0;
        end else if (clear_i) begin
            count_o <= '0;
        end else if (inc_i) begin
            // Counts past the range, the mapper wraps it
            count_o.flat <= count_o.flat + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/glb_ctrl_pkg.sv
// Control types: FSM state enum, beat address union and beat count type
`default_nettype none

package glb_ctrl_pkg;

    import glb_geom_pkg::*;

    // ==========================================================
    // Flow state
    // ==========================================================
    typedef enum logic {
        GLB_IDLE = 1'b0,
        GLB_RUN  = 1'b1
    } glb_state_e;

    // ==========================================================
    // Beat address
    // ==========================================================
    // Bank-step view, upper bits pick the bank group
    typedef struct packed {
        logic [ADDR_W-ROW_W-1:0] step;
        logic [ROW_W-1:0]        row;
    } glb_addr_split_t;

    // Flat count or bank step plus row
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        glb_addr_split_t   split;
    } glb_addr_u;

    // Beat count used for lengths, ranges and status numbers
    typedef logic [ADDR_W-1:0] glb_count_t;

endpackage

`default_nettype wire

//--- verilog/glb_geom_pkg.sv
// Buffer geometry constants for banks, rows, lanes and address widths
`default_nettype none

package glb_geom_pkg;

    // ==========================================================
    // Bank organisation
    // ==========================================================
    localparam int NUM_BANK   = 4;
    localparam int ROW_W      = 4;
    localparam int BANK_WORDS = 16;

    // Lane and beat widths
    localparam int LANE_W  = 8;
    localparam int MAX_PAR = 2;
    localparam int DATA_W  = LANE_W * MAX_PAR;

    // ==========================================================
    // Index and count widths
    // ==========================================================
    localparam int ADDR_W     = 8;
    localparam int BANK_IDX_W = 2;
    localparam int PAR_W      = 2;
    // Bank count from 0 up to NUM_BANK
    localparam int NBANK_W    = 3;

endpackage

`default_nettype wire
